/* Bender.yml */
package:
  name: fe_loader

export_include_dirs:
  - .

sources:
  - files:
      - feLoaderPkg.sv
      - loadWordIf.sv
      - asciiWordDecoder.sv
      - loadLineParser.sv
      - ramWordAssembler.sv
      - ucodeVersionCapture.sv
      - feLoaderTop.sv
  - target: simulation
    files:
      - tbFeLoader.sv

/* asciiWordDecoder.sv */
// Character stream decoder turning ASCIIized fields into 16-bit words
`timescale 1ns/1ps
`include "feLoaderDefines.svh"

module asciiWordDecoder (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  charValid,
  input  feLoaderPkg::loadCharT charData,
  loadWordIf.source             words
);
  import feLoaderPkg::*;

  logic       inLineQ;
  logic       discardQ;
  recordKindT kindQ;
  loadWordT   accQ;
  logic [7:0] indexQ;

  logic       isNewline;
  logic       isComma;
  logic       isBlank;
  logic       publish;
  recordKindT letterKind;

  ////////////////////////////////////////
  // Character classes
  ////////////////////////////////////////

  always_comb begin
    isNewline = charData == `LD_CHAR_NEWLINE;
    isComma   = charData == `LD_CHAR_COMMA;
    isBlank   = (charData == `LD_CHAR_CR) || (charData == `LD_CHAR_SPACE);
    // A word ends on comma or newline inside a live line
    publish   = charValid && inLineQ && !discardQ && (isComma || isNewline);
    case (charData)
      7'h43:          letterKind = kindCrama;   // C
      7'h44:          letterKind = kindDrama;   // D
      7'h5A:          letterKind = kindZero;    // Z
      `LD_CHAR_SEMI:  letterKind = kindComment;
      default:        letterKind = kindUnknown;
    endcase
  end

  ////////////////////////////////////////
  // Line state and accumulator
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      inLineQ         <= 1'b0;
      discardQ        <= 1'b0;
      kindQ           <= kindNone;
      accQ            <= '0;
      indexQ          <= '0;
      words.wordValid <= 1'b0;
      words.lineEnd   <= 1'b0;
      words.kind      <= kindNone;
    end else begin
      words.wordValid <= publish;
      words.lineEnd   <= publish && isNewline;
      if (publish) begin
        words.kind <= kindQ;
      end
      if (charValid) begin
        if (isNewline) begin
          // End of line, comment or not
          inLineQ  <= 1'b0;
          discardQ <= 1'b0;
          accQ     <= '0;
          indexQ   <= '0;
        end else if (discardQ || isBlank) begin
          // Comment text, CR and space are dropped
        end else if (!inLineQ) begin
          inLineQ  <= 1'b1;
          kindQ    <= letterKind;
          discardQ <= letterKind == kindComment;
        end else if (isComma) begin
          accQ <= '0;
          if (indexQ != 8'hFF) begin
            indexQ <= indexQ + 8'd1;
          end
        end else begin
          // First character is most significant
          accQ <= {accQ[`LD_WORD_BITS-`LD_FIELD_BITS-1:0], charData[`LD_FIELD_BITS-1:0]};
        end
      end
    end
  end

  // Published word and its position
  always_ff @(posedge clk) begin
    if (publish) begin
      words.word      <= accQ;
      words.wordIndex <= indexQ;
    end
  end

endmodule

/* feLoaderDefines.svh */
// Loader constants for character codes, field widths and version locations
`ifndef FE_LOADER_DEFINES_SVH
`define FE_LOADER_DEFINES_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

// Data word as sent by the front end
`define LD_WORD_BITS       16
// Payload bits carried by one ASCIIized character
`define LD_FIELD_BITS      6
`define LD_CHAR_BITS       7
`define LD_CRAM_ADDR_BITS  11
`define LD_DRAM_ADDR_BITS  8
// 80 data bits plus the CALL/DISP special field
`define LD_CRAM_BITS       86

// CRAM locations holding the microcode version
`define LD_VERSION_LOC0    11'o136
`define LD_VERSION_LOC1    11'o137

////////////////////////////////////////
// Separator characters
////////////////////////////////////////

`define LD_CHAR_COMMA      7'h2C
`define LD_CHAR_NEWLINE    7'h0A
`define LD_CHAR_CR         7'h0D
`define LD_CHAR_SPACE      7'h20
`define LD_CHAR_SEMI       7'h3B

`endif

/* feLoaderPkg.sv */
// Shared loader types for words, addresses, RAM payloads and record kinds
`include "feLoaderDefines.svh"

package feLoaderPkg;

  typedef logic [`LD_WORD_BITS-1:0]      loadWordT;
  typedef logic [`LD_CHAR_BITS-1:0]      loadCharT;
  typedef logic [`LD_CRAM_ADDR_BITS-1:0] cramAddrT;
  typedef logic [`LD_DRAM_ADDR_BITS-1:0] dramAddrT;

  // Record type from the first character of a line
  typedef enum logic [2:0] {
    kindNone,
    kindCrama,
    kindDrama,
    kindZero,
    kindComment,
    kindUnknown
  } recordKindT;

  // CRAM word, special field on top, then CRAM bits 0-15 down to 64-79
  // Within each field the lowest CRAM bit number is the field's MSB
  typedef struct packed {
    logic [`LD_CRAM_BITS-5*`LD_WORD_BITS-1:0] special;
    loadWordT bits00to15;
    loadWordT bits16to31;
    loadWordT bits32to47;
    loadWordT bits48to63;
    loadWordT bits64to79;
  } cramWordT;

  // DRAM location pair as loaded by WDRAM
  typedef struct packed {
    loadWordT common;
    loadWordT odd;
    loadWordT even;
  } dramPairT;

endpackage

/* feLoaderTop.sv */
// Microcode loader top, character stream in and CRAM/DRAM writes out
`timescale 1ns/1ps

module feLoaderTop (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  charValid,
  input  feLoaderPkg::loadCharT charData,
  output logic                  cramWe,
  output feLoaderPkg::cramAddrT cramAddr,
  output feLoaderPkg::cramWordT cramData,
  output logic                  dramWe,
  output feLoaderPkg::dramAddrT dramAddr,
  output feLoaderPkg::dramPairT dramData,
  output logic                  checksumError,
  output logic                  recordError,
  output logic                  versionValid,
  output logic [5:0]            majorVersion,
  output logic [2:0]            minorVersion,
  output logic [8:0]            editNumber
);
  import feLoaderPkg::*;

  loadWordIf wordBus ();

  logic     cramDataValid;
  loadWordT cramDataWord;
  cramAddrT cramLineAddr;
  logic     dramDataValid;
  loadWordT dramDataWord;
  dramAddrT dramLineAddr;

  ////////////////////////////////////////
  // Decode and parse
  ////////////////////////////////////////

  asciiWordDecoder decoder (
    .clk       (clk),
    .arstN     (arstN),
    .charValid (charValid),
    .charData  (charData),
    .words     (wordBus.source)
  );

  loadLineParser parser (
    .clk           (clk),
    .arstN         (arstN),
    .words         (wordBus.sink),
    .cramDataValid (cramDataValid),
    .cramDataWord  (cramDataWord),
    .cramLineAddr  (cramLineAddr),
    .dramDataValid (dramDataValid),
    .dramDataWord  (dramDataWord),
    .dramLineAddr  (dramLineAddr),
    .checksumError (checksumError),
    .recordError   (recordError)
  );

  ////////////////////////////////////////
  // Location assembly
  ////////////////////////////////////////

  // Six words per CRAM location
  ramWordAssembler #(
    .payloadT (cramWordT),
    .addrT    (cramAddrT)
  ) cramAssembler (
    .clk       (clk),
    .arstN     (arstN),
    .dataValid (cramDataValid),
    .dataWord  (cramDataWord),
    .lineAddr  (cramLineAddr),
    .we        (cramWe),
    .writeAddr (cramAddr),
    .writeData (cramData)
  );

  // Three words per DRAM pair
  ramWordAssembler #(
    .payloadT (dramPairT),
    .addrT    (dramAddrT)
  ) dramAssembler (
    .clk       (clk),
    .arstN     (arstN),
    .dataValid (dramDataValid),
    .dataWord  (dramDataWord),
    .lineAddr  (dramLineAddr),
    .we        (dramWe),
    .writeAddr (dramAddr),
    .writeData (dramData)
  );

  ucodeVersionCapture versionCapture (
    .clk          (clk),
    .arstN        (arstN),
    .cramWe       (cramWe),
    .cramAddr     (cramAddr),
    .cramData     (cramData),
    .versionValid (versionValid),
    .majorVersion (majorVersion),
    .minorVersion (minorVersion),
    .editNumber   (editNumber)
  );

endmodule

/* files.f */
+incdir+.
feLoaderPkg.sv
loadWordIf.sv
asciiWordDecoder.sv
loadLineParser.sv
ramWordAssembler.sv
ucodeVersionCapture.sv
feLoaderTop.sv
tbFeLoader.sv

/* loadLineParser.sv */
// Line parser checking word count and checksum and routing addressed data words
`timescale 1ns/1ps
`include "feLoaderDefines.svh"

module loadLineParser (
  input  logic                  clk,
  input  logic                  arstN,
  loadWordIf.sink               words,
  output logic                  cramDataValid,
  output feLoaderPkg::loadWordT cramDataWord,
  output feLoaderPkg::cramAddrT cramLineAddr,
  output logic                  dramDataValid,
  output feLoaderPkg::loadWordT dramDataWord,
  output feLoaderPkg::dramAddrT dramLineAddr,
  output logic                  checksumError,
  output logic                  recordError
);
  import feLoaderPkg::*;

  // Words per location, from the payload widths
  localparam int CramWordsPerLoc = ($bits(cramWordT) + `LD_WORD_BITS - 1) / `LD_WORD_BITS;
  localparam int DramWordsPerLoc = ($bits(dramPairT) + `LD_WORD_BITS - 1) / `LD_WORD_BITS;

  loadWordT   wcQ;
  loadWordT   sumQ;
  logic [2:0] subCountQ;
  cramAddrT   cramAddrQ;
  dramAddrT   dramAddrQ;
  logic       checksumSeenQ;

  loadWordT   position;
  loadWordT   sumNext;
  logic       knownKind;
  logic       isData;
  logic       isChecksum;
  logic       isExtra;
  logic       locDone;
  logic [2:0] lastSub;

  ////////////////////////////////////////
  // Word classification
  ////////////////////////////////////////

  always_comb begin
    position   = loadWordT'(words.wordIndex);
    knownKind  = (words.kind == kindCrama) || (words.kind == kindDrama) ||
                 (words.kind == kindZero);
    // Data words sit at positions 2 through WC+1, checksum at WC+2
    isData     = words.wordValid && (position >= 2) && ((position - loadWordT'(2)) < wcQ);
    isChecksum = words.wordValid && (position >= 2) && ((position - loadWordT'(2)) == wcQ);
    isExtra    = words.wordValid && (position >= 2) && ((position - loadWordT'(2)) > wcQ);
    // Running sum including the word now arriving
    if (!words.wordValid) begin
      sumNext = sumQ;
    end else if (position == 0) begin
      sumNext = words.word;
    end else begin
      sumNext = sumQ + words.word;
    end
    lastSub = (words.kind == kindDrama) ? 3'(DramWordsPerLoc - 1) : 3'(CramWordsPerLoc - 1);
    locDone = subCountQ == lastSub;
  end

  ////////////////////////////////////////
  // Line state, addresses and flags
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wcQ           <= '0;
      sumQ          <= '0;
      subCountQ     <= '0;
      cramAddrQ     <= '0;
      dramAddrQ     <= '0;
      checksumSeenQ <= 1'b0;
      cramDataValid <= 1'b0;
      dramDataValid <= 1'b0;
      checksumError <= 1'b0;
      recordError   <= 1'b0;
    end else begin
      cramDataValid <= isData && (words.kind == kindCrama);
      dramDataValid <= isData && (words.kind == kindDrama);
      if (words.wordValid) begin
        sumQ <= sumNext;
      end
      if (words.wordValid && (position == 0)) begin
        wcQ <= words.word;
      end
      // Nonzero ADR restarts, zero ADR continues from the last address
      if (words.wordValid && (position == 1)) begin
        subCountQ <= '0;
        if ((words.word != '0) && (wcQ != '0)) begin
          if (words.kind == kindCrama) begin
            cramAddrQ <= cramAddrT'(words.word);
          end
          if (words.kind == kindDrama) begin
            dramAddrQ <= dramAddrT'(words.word);
          end
        end
      end
      // Step the address after each whole location
      if (isData) begin
        if (locDone) begin
          subCountQ <= '0;
          if (words.kind == kindCrama) begin
            cramAddrQ <= cramAddrQ + cramAddrT'(1);
          end
          if (words.kind == kindDrama) begin
            dramAddrQ <= dramAddrQ + dramAddrT'(2);
          end
        end else begin
          subCountQ <= subCountQ + 3'd1;
        end
      end
      if (isChecksum) begin
        checksumSeenQ <= 1'b1;
      end
      if (words.lineEnd) begin
        checksumSeenQ <= 1'b0;
      end
      // Sticky error flags
      if (words.lineEnd && knownKind && (sumNext != '0)) begin
        checksumError <= 1'b1;
      end
      if (words.wordValid && (words.kind == kindUnknown)) begin
        recordError <= 1'b1;
      end
      if (isExtra) begin
        recordError <= 1'b1;
      end
      // Line ended before its checksum word
      if (words.lineEnd && knownKind && !(checksumSeenQ || isChecksum)) begin
        recordError <= 1'b1;
      end
    end
  end

  // Data word and location address toward the assemblers
  always_ff @(posedge clk) begin
    if (isData) begin
      cramDataWord <= words.word;
      cramLineAddr <= cramAddrQ;
      dramDataWord <= words.word;
      dramLineAddr <= dramAddrQ;
    end
  end

endmodule

/* loadWordIf.sv */
// Word bus carrying decoded load file words from decoder to line parser
`timescale 1ns/1ps

interface loadWordIf ();
  import feLoaderPkg::*;

  // One cycle strobe per published word
  logic       wordValid;
  loadWordT   word;
  // Position after the record letter, saturates at 255
  logic [7:0] wordIndex;
  recordKindT kind;
  // Newline strobe, may share a cycle with the last word
  logic       lineEnd;

  modport source (
    output wordValid, word, wordIndex, kind, lineEnd
  );

  modport sink (
    input wordValid, word, wordIndex, kind, lineEnd
  );

endinterface

/* ramWordAssembler.sv */
// RAM word assembler collecting 16-bit words into one addressed payload write
`timescale 1ns/1ps
`include "feLoaderDefines.svh"

module ramWordAssembler #(
  parameter type payloadT = feLoaderPkg::dramPairT,
  parameter type addrT    = feLoaderPkg::dramAddrT
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  dataValid,
  input  feLoaderPkg::loadWordT dataWord,
  input  addrT                  lineAddr,
  output logic                  we,
  output addrT                  writeAddr,
  output payloadT               writeData
);
  import feLoaderPkg::*;

  localparam int PayloadBits     = $bits(payloadT);
  // Whole words needed to cover the payload
  localparam int WordsPerPayload = (PayloadBits + `LD_WORD_BITS - 1) / `LD_WORD_BITS;
  localparam int CountBits       = (WordsPerPayload > 1) ? $clog2(WordsPerPayload) : 1;

  loadWordT [WordsPerPayload-1:0] shiftQ;
  logic     [CountBits-1:0]       countQ;
  logic                           lastWord;

  assign lastWord = countQ == CountBits'(WordsPerPayload - 1);

  ////////////////////////////////////////
  // Word count and write strobe
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      countQ <= '0;
      we     <= 1'b0;
    end else begin
      we <= dataValid && lastWord;
      if (dataValid) begin
        if (lastWord) begin
          countQ <= '0;
        end else begin
          countQ <= countQ + CountBits'(1);
        end
      end
    end
  end

  // Newest word enters on top, older words move down
  always_ff @(posedge clk) begin
    if (dataValid) begin
      shiftQ <= {dataWord, shiftQ[WordsPerPayload-1:1]};
      if (lastWord) begin
        writeAddr <= lineAddr;
      end
    end
  end

  // Payload is the low bits of the full register
  assign writeData = payloadT'(PayloadBits'(shiftQ));

endmodule

/* tbFeLoader.sv */
// Testbench for the microcode loader driving ASCIIized lines and checking CRAM and DRAM writes
`timescale 1ns/1ps
`include "feLoaderDefines.svh"

module tbFeLoader;
  import feLoaderPkg::*;

  // Record letters
  localparam loadCharT LetterC    = 7'h43;
  localparam loadCharT LetterD    = 7'h44;
  localparam loadCharT LetterZ    = 7'h5A;
  localparam loadCharT LetterX    = 7'h58;
  localparam loadCharT LetterSemi = `LD_CHAR_SEMI;

  typedef struct packed {
    cramAddrT addr;
    cramWordT data;
  } cramWriteT;

  typedef struct packed {
    dramAddrT addr;
    dramPairT data;
  } dramWriteT;

  logic       clk = 1'b0;
  logic       arstN;
  logic       charValid;
  loadCharT   charData;
  logic       cramWe;
  cramAddrT   cramAddr;
  cramWordT   cramData;
  logic       dramWe;
  dramAddrT   dramAddr;
  dramPairT   dramData;
  logic       checksumError;
  logic       recordError;
  logic       versionValid;
  logic [5:0] majorVersion;
  logic [2:0] minorVersion;
  logic [8:0] editNumber;

  // Scoreboard queues and their current heads
  cramWriteT cramQueue[$];
  dramWriteT dramQueue[$];
  cramWriteT expCram;
  dramWriteT expDram;
  logic      expCramValid = 1'b0;
  logic      expDramValid = 1'b0;

  // Line being built
  loadWordT lineWords[$];
  loadCharT lineChars[$];

  logic [31:0] rngState   = 32'd96;
  int          charsSent  = 0;
  int          cycleCount = 0;

  // Expected flags and version
  logic       expChecksumError = 1'b0;
  logic       expRecordError   = 1'b0;
  logic       expVersionValid  = 1'b0;
  logic [5:0] expMajor;
  logic [2:0] expMinor;
  logic [8:0] expEdit;
  cramAddrT   cramLast = '0;
  dramAddrT   dramLast = '0;
  cramWordT   version0;
  cramWordT   version1;

  feLoaderTop DUT (
    .clk           (clk),
    .arstN         (arstN),
    .charValid     (charValid),
    .charData      (charData),
    .cramWe        (cramWe),
    .cramAddr      (cramAddr),
    .cramData      (cramData),
    .dramWe        (dramWe),
    .dramAddr      (dramAddr),
    .dramData      (dramData),
    .checksumError (checksumError),
    .recordError   (recordError),
    .versionValid  (versionValid),
    .majorVersion  (majorVersion),
    .minorVersion  (minorVersion),
    .editNumber    (editNumber)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic abortRun();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic reportValue(string sigName, logic [95:0] got, logic [95:0] exp);
    $display("error at %0t ns: %s is %0h, expected %0h", $time, sigName, got, exp);
  endtask

  task automatic checkValue(string sigName, logic [95:0] got, logic [95:0] exp);
    assert (got === exp) else begin
      reportValue(sigName, got, exp);
      abortRun();
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // xorshift32 with the low half used as a data word
  function automatic loadWordT nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState[15:0];
  endfunction

  // Six bits per character plus octal 100 with the most significant first
  function automatic void appendWord(loadWordT value);
    logic [5:0] fields [3];
    int         first;
    fields[0] = {2'b00, value[15:12]};
    fields[1] = value[11:6];
    fields[2] = value[5:0];
    // Leading zero fields dropped, so zero is an empty field
    first = 3;
    for (int i = 2; i >= 0; i--) begin
      if (fields[i] != 6'd0) begin
        first = i;
      end
    end
    for (int i = first; i < 3; i++) begin
      lineChars.push_back(loadCharT'(7'o100 + fields[i]));
    end
  endfunction

  // Letter, space, words with commas, negated sum, CR and newline
  function automatic void buildLine(loadCharT letter, loadWordT skew);
    loadWordT sum;
    sum = '0;
    lineChars.delete();
    lineChars.push_back(letter);
    lineChars.push_back(`LD_CHAR_SPACE);
    foreach (lineWords[i]) begin
      sum = sum + lineWords[i];
      appendWord(lineWords[i]);
      lineChars.push_back(`LD_CHAR_COMMA);
    end
    // Nonzero skew breaks the checksum
    appendWord(loadWordT'(16'd0 - sum + skew));
    lineChars.push_back(`LD_CHAR_CR);
    lineChars.push_back(`LD_CHAR_NEWLINE);
  endfunction

  // WC, ADR, then WC random data words
  task automatic startLine(loadWordT wc, loadWordT adr);
    lineWords.delete();
    lineWords.push_back(wc);
    lineWords.push_back(adr);
    for (int i = 0; i < int'(wc); i++) begin
      lineWords.push_back(nextRandom());
    end
  endtask

  // First data word lands lowest in the CRAM word
  task automatic expectCramLine(cramAddrT startAddr, int locations);
    cramWriteT entry;
    int        base;
    for (int loc = 0; loc < locations; loc++) begin
      base                  = 2 + 6 * loc;
      entry.addr            = startAddr + cramAddrT'(loc);
      entry.data.bits64to79 = lineWords[base];
      entry.data.bits48to63 = lineWords[base + 1];
      entry.data.bits32to47 = lineWords[base + 2];
      entry.data.bits16to31 = lineWords[base + 3];
      entry.data.bits00to15 = lineWords[base + 4];
      entry.data.special    = lineWords[base + 5][5:0];
      cramQueue.push_back(entry);
    end
    cramLast = startAddr + cramAddrT'(locations);
  endtask

  // Even, odd and common in word order with two addresses per pair
  task automatic expectDramLine(dramAddrT startAddr, int pairs);
    dramWriteT entry;
    int        base;
    for (int loc = 0; loc < pairs; loc++) begin
      base              = 2 + 3 * loc;
      entry.addr        = startAddr + dramAddrT'(2 * loc);
      entry.data.even   = lineWords[base];
      entry.data.odd    = lineWords[base + 1];
      entry.data.common = lineWords[base + 2];
      dramQueue.push_back(entry);
    end
    dramLast = startAddr + dramAddrT'(2 * pairs);
  endtask

  task automatic sendLine();
    foreach (lineChars[i]) begin
      @(negedge clk);
      charValid = 1'b1;
      charData  = lineChars[i];
      charsSent = charsSent + 1;
    end
    @(negedge clk);
    charValid = 1'b0;
    charData  = '0;
  endtask

  // Wait for all expected writes, then check the flags
  task automatic finishLine();
    while ((cramQueue.size() != 0) || (dramQueue.size() != 0)) begin
      @(negedge clk);
    end
    // Flags land two edges after the newline and writes three
    repeat (4) @(negedge clk);
    checkValue("checksumError", checksumError, expChecksumError);
    checkValue("recordError", recordError, expRecordError);
    checkValue("versionValid", versionValid, expVersionValid);
    if (expVersionValid) begin
      checkValue("majorVersion", majorVersion, expMajor);
      checkValue("minorVersion", minorVersion, expMinor);
      checkValue("editNumber", editNumber, expEdit);
    end
  endtask

  // CRAM bit n where bit 0 is the MSB of the bits 0-15 field
  function automatic logic cramBit(cramWordT word, int n);
    logic [`LD_CRAM_BITS-1:0] flat;
    flat = word;
    return flat[5 * `LD_WORD_BITS - 1 - n];
  endfunction

  function automatic logic [2:0] cramTriple(cramWordT word, int first);
    return {cramBit(word, first), cramBit(word, first + 1), cramBit(word, first + 2)};
  endfunction

  ////////////////////////////////////////
  // Scoreboard and write checks
  ////////////////////////////////////////

  // Pop on the edge that ends a write strobe so the head stays stable in between
  always @(posedge clk) begin
    if (cramWe && (cramQueue.size() != 0)) begin
      cramQueue.delete(0);
    end
    if (dramWe && (dramQueue.size() != 0)) begin
      dramQueue.delete(0);
    end
    expCramValid = cramQueue.size() != 0;
    expDramValid = dramQueue.size() != 0;
    if (expCramValid) begin
      expCram = cramQueue[0];
    end
    if (expDramValid) begin
      expDram = dramQueue[0];
    end
  end

  cramWriteCheck: assert property (@(negedge clk) disable iff (!arstN)
    cramWe |-> (expCramValid && (cramAddr == expCram.addr) && (cramData == expCram.data)))
  else begin
    if (!expCramValid) begin
      $display("error at %0t ns: cramWe raised while no CRAM write was expected", $time);
    end else begin
      reportValue("cramAddr", cramAddr, expCram.addr);
      reportValue("cramData", cramData, expCram.data);
    end
    abortRun();
  end

  dramWriteCheck: assert property (@(negedge clk) disable iff (!arstN)
    dramWe |-> (expDramValid && (dramAddr == expDram.addr) && (dramData == expDram.data)))
  else begin
    if (!expDramValid) begin
      $display("error at %0t ns: dramWe raised while no DRAM write was expected", $time);
    end else begin
      reportValue("dramAddr", dramAddr, expDram.addr);
      reportValue("dramData", dramData, expDram.data);
    end
    abortRun();
  end

  // Watchdog allowing 20 cycles per character plus slack
  initial begin
    while (cycleCount <= 20 * charsSent + 100) begin
      @(posedge clk);
      cycleCount = cycleCount + 1;
    end
    $display("error at %0t ns: timeout, the loader stopped making progress", $time);
    abortRun();
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    arstN     = 1'b0;
    charValid = 1'b0;
    charData  = '0;
    repeat (3) @(negedge clk);
    checkValue("cramWe", cramWe, 1'b0);
    checkValue("dramWe", dramWe, 1'b0);
    checkValue("checksumError", checksumError, 1'b0);
    checkValue("recordError", recordError, 1'b0);
    checkValue("versionValid", versionValid, 1'b0);
    arstN = 1'b1;

    // Two CRAM locations
    startLine(16'd12, 16'o200);
    expectCramLine(11'o200, 2);
    buildLine(LetterC, '0);
    sendLine();
    finishLine();

    // Three DRAM pairs
    startLine(16'd9, 16'd32);
    expectDramLine(8'd32, 3);
    buildLine(LetterD, '0);
    sendLine();
    finishLine();

    // Zero ADR continues each type
    startLine(16'd6, 16'd0);
    expectCramLine(cramLast, 1);
    buildLine(LetterC, '0);
    sendLine();
    finishLine();
    startLine(16'd3, 16'd0);
    expectDramLine(dramLast, 1);
    buildLine(LetterD, '0);
    sendLine();
    finishLine();

    // No writes from WC zero, comment or Z lines
    startLine(16'd0, 16'o500);
    buildLine(LetterC, '0);
    sendLine();
    finishLine();
    startLine(16'd6, 16'o600);
    buildLine(LetterSemi, '0);
    sendLine();
    finishLine();
    startLine(16'd2, 16'o300);
    buildLine(LetterZ, '0);
    sendLine();
    finishLine();

    // Version locations
    startLine(16'd12, 16'o136);
    expectCramLine(11'o136, 2);
    version0        = cramQueue[0].data;
    version1        = cramQueue[1].data;
    expMajor        = {cramTriple(version0, 29), cramTriple(version0, 33)};
    expMinor        = cramTriple(version0, 37);
    expEdit         = {cramTriple(version1, 29), cramTriple(version1, 33),
                       cramTriple(version1, 37)};
    expVersionValid = 1'b1;
    buildLine(LetterC, '0);
    sendLine();
    finishLine();

    // Unknown record letter
    startLine(16'd3, 16'o10);
    expRecordError = 1'b1;
    buildLine(LetterX, '0);
    sendLine();
    finishLine();

    // Checksum off by one
    startLine(16'd2, 16'o310);
    expChecksumError = 1'b1;
    buildLine(LetterZ, 16'd1);
    sendLine();
    finishLine();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* ucodeVersionCapture.sv */
// Microcode version capture from CRAM writes to locations 136 and 137
`timescale 1ns/1ps
`include "feLoaderDefines.svh"

module ucodeVersionCapture (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  cramWe,
  input  feLoaderPkg::cramAddrT cramAddr,
  input  feLoaderPkg::cramWordT cramData,
  output logic                  versionValid,
  output logic [5:0]            majorVersion,
  output logic [2:0]            minorVersion,
  output logic [8:0]            editNumber
);

  logic       seenLoc0Q;
  logic       hitLoc0;
  logic       hitLoc1;
  logic [2:0] fieldA;
  logic [2:0] fieldB;
  logic [2:0] fieldC;

  // CRAM bit n of a field is its bit (last field bit - n)
  always_comb begin
    fieldA  = cramData.bits16to31[2:0];    // CRAM 29-31
    fieldB  = cramData.bits32to47[14:12];  // CRAM 33-35
    fieldC  = cramData.bits32to47[10:8];   // CRAM 37-39
    hitLoc0 = cramWe && (cramAddr == `LD_VERSION_LOC0);
    hitLoc1 = cramWe && (cramAddr == `LD_VERSION_LOC1);
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      seenLoc0Q    <= 1'b0;
      versionValid <= 1'b0;
    end else begin
      if (hitLoc0) begin
        seenLoc0Q <= 1'b1;
      end
      // Valid only once both locations have been loaded in order
      if (hitLoc1 && seenLoc0Q) begin
        versionValid <= 1'b1;
      end
    end
  end

  // Version fields
  always_ff @(posedge clk) begin
    if (hitLoc0) begin
      majorVersion <= {fieldA, fieldB};
      minorVersion <= fieldC;
    end
    if (hitLoc1) begin
      editNumber <= {fieldA, fieldB, fieldC};
    end
  end

endmodule
